// File: tb.f
+incdir+.
sdmac_pkg.sv
sdmac_addr_decode.sv
sdmac_registers.sv
sdmac_io_port.sv
sdmac_bus_response.sv
sdmac_top.sv
tb_sdmac.sv

// File: Makefile
# Verilator flow for the SDMAC slave testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tb_sdmac with Verilator, run it and check for the pass line"
	@echo "  clean  remove obj_dir"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_sdmac -f tb.f
	@out="$$(./obj_dir/Vtb_sdmac)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: tb_sdmac.sv
// Testbench for the SDMAC slave; applies a table of CPU bus cycles to sdmac_top and checks replies
`timescale 1ns/1ps
`include "sdmac_defs.svh"

module tb_sdmac;

    typedef struct packed {
        logic        r_w;       // High for read
        logic [6:2]  addr;
        logic [31:0] wdata;
        logic [1:0]  ints;      // {intb, inta} set before the cycle
        logic        acked;     // Low for the hole
        logic [1:0]  dsack;
        logic [31:0] data;      // Expected read data
        logic [2:0]  cs;        // {csx1_n, csx0_n, css_n} under the strobe
    } step_t;

    localparam int ack_limit = 40;  // Clocks allowed for any dsack_n change

    logic        sclk = 1'b0;
    logic        reset;
    logic        cs_n, as_n, ds_n;
    logic        r_w;
    logic [6:2]  addr;
    logic [31:0] data_in;
    logic [31:0] data_out;
    logic        data_oe;
    logic [1:0]  dsack_n;
    logic        css_n, csx0_n, csx1_n;
    logic        ior_n, iow_n;
    logic [15:0] pd_in = 16'h0000;  // Driven by the SCSI chip model
    logic [15:0] pd_out;
    logic        pd_oe;
    logic        inta, intb;
    logic [15:0] pd_next = 16'h0000;
    logic [15:0] pd_cap = 16'h0000; // Last word written to the chip
    logic [2:0]  cs_seen = 3'b111;
    int          ior_cnt = 0;       // Strobe clocks seen by the chip model
    int          iow_cnt = 0;
    integer      seed;
    step_t       steps[$];

    sdmac_top dut0 (.*);

    always #10 sclk = ~sclk;

    function automatic logic [15:0] port_value(input logic [1:0] sel);
        case (sel)
            2'd0:    return 16'h5a31;   // css_n
            2'd3:    return 16'h9e47;   // csx1_n
            default: return 16'hc0de;   // csx0_n covers 1 and 2
        endcase
    endfunction

    function automatic logic [2:0] cs_for(input logic [1:0] sel);
        case (sel)
            2'd0:    return 3'b110;
            2'd3:    return 3'b011;
            default: return 3'b101;
        endcase
    endfunction

    // SCSI chip model
    always @(negedge sclk) begin
        pd_next <= !css_n ? port_value(2'd0) : !csx0_n ? port_value(2'd1) :
                   !csx1_n ? port_value(2'd3) : 16'h0000;
        if (!ior_n || !iow_n)
            cs_seen <= {csx1_n, csx0_n, css_n};
        if (!ior_n) begin
            ior_cnt <= ior_cnt + 1;
            check(32'(pd_oe), 32'd0, "pd_oe under ior_n");  // Chip owns the data lines
        end
        if (!iow_n) begin
            iow_cnt <= iow_cnt + 1;
            pd_cap  <= pd_out;
            check(32'(pd_oe), 32'd1, "pd_oe under iow_n");
        end
    end

    always @(posedge sclk)
        pd_in <= pd_next;

    task automatic end_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        end_with_failure();
    endtask

    // Expected reply derived from the address class
    task automatic add_step(input logic rd, input logic [6:2] a, input logic [31:0] wd,
                            input logic [1:0] ia, input logic [31:0] d);
        step_t s;
        s.r_w   = rd;
        s.addr  = a;
        s.wdata = wd;
        s.ints  = ia;
        s.acked = a[6] || (a[5:2] != `SDMAC_REG_HOLE);
        s.dsack = a[6] ? 2'b01 : 2'b00;     // 16-bit port acks on DSACK1 only
        s.data  = d;
        s.cs    = a[6] ? cs_for(a[3:2]) : 3'b111;
        steps.push_back(s);
    endtask

    task automatic build_table();
        logic [31:0] w;
        add_step(1'b1, {1'b0, `SDMAC_REG_CNTR}, 32'h0, 2'b00, 32'(`SDMAC_CNTR_RESET));
        w = $random(seed);
        add_step(1'b0, {1'b0, `SDMAC_REG_DAWR}, w, 2'b00, 32'h0);
        add_step(1'b1, {1'b0, `SDMAC_REG_DAWR}, 32'h0, 2'b00, w);
        w = $random(seed);
        add_step(1'b0, {1'b0, `SDMAC_REG_WTC}, w, 2'b00, 32'h0);
        add_step(1'b1, {1'b0, `SDMAC_REG_WTC}, 32'h0, 2'b00, w & 32'h00ff_ffff);
        w = $random(seed);
        add_step(1'b0, {1'b0, `SDMAC_REG_CNTR}, w, 2'b00, 32'h0);
        add_step(1'b1, {1'b0, `SDMAC_REG_CNTR}, 32'h0, 2'b00, w & 32'h0000_01ff);
        // Status follows inta and intb and ignores writes
        add_step(1'b1, {1'b0, `SDMAC_REG_ISTR}, 32'h0, 2'b01, 32'h1);
        add_step(1'b0, {1'b0, `SDMAC_REG_ISTR}, $random(seed), 2'b10, 32'h0);
        add_step(1'b1, {1'b0, `SDMAC_REG_ISTR}, 32'h0, 2'b10, 32'h2);
        add_step(1'b1, {1'b0, `SDMAC_REG_ISTR}, 32'h0, 2'b11, 32'h3);
        add_step(1'b1, 5'h05, 32'h0, 2'b00, 32'h0);        // Unused offsets
        add_step(1'b1, 5'h0f, 32'h0, 2'b00, 32'h0);
        for (int sel = 0; sel < 4; sel++) begin
            add_step(1'b0, {3'b100, 2'(sel)}, $random(seed), 2'b00, 32'h0);
            add_step(1'b1, {3'b100, 2'(sel)}, 32'h0, 2'b00, {2{port_value(2'(sel))}});
        end
        add_step(1'b1, {1'b0, `SDMAC_REG_HOLE}, 32'h0, 2'b00, 32'h0);
        add_step(1'b0, {1'b0, `SDMAC_REG_HOLE}, $random(seed), 2'b00, 32'h0);
    endtask

    // One full CPU bus cycle with its checks
    task automatic run_step(input step_t s);
        int   n;
        int   ior_base;
        int   iow_base;
        logic seen;
        @(posedge sclk);
        inta     <= s.ints[0];
        intb     <= s.ints[1];
        ior_base = ior_cnt;
        iow_base = iow_cnt;
        @(posedge sclk);
        r_w     <= s.r_w;
        addr    <= s.addr;
        data_in <= s.wdata;
        cs_n    <= 1'b0;
        as_n    <= 1'b0;
        ds_n    <= 1'b0;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < ack_limit) begin
            @(negedge sclk);
            seen = (dsack_n != 2'b11);
            n++;
        end
        if (s.acked) begin
            if (!seen)
                timeout_fail("no dsack_n for an access that must be acknowledged");
            check(32'(dsack_n), 32'(s.dsack), "dsack_n width");
            check(32'(data_oe), 32'(s.r_w), "data_oe");
            if (s.r_w)
                check(data_out, s.data, "read data");
        end else begin
            check(32'(dsack_n), 32'h3, "dsack_n on the hole");  // Silence is expected
        end
        @(posedge sclk);
        cs_n <= 1'b1;
        as_n <= 1'b1;
        ds_n <= 1'b1;
        n = 0;
        while (seen && n < ack_limit) begin
            @(negedge sclk);
            seen = (dsack_n != 2'b11);
            n++;
        end
        if (seen)
            timeout_fail("dsack_n stayed asserted after as_n went high");
        check(32'(data_oe), 32'h0, "data_oe after the bus cycle");   // Dropped with dsack_n
        if (s.addr[6]) begin
            check(32'(cs_seen), 32'(s.cs), "chip selects under the strobe");
            check(32'(ior_cnt - ior_base), s.r_w ? `SDMAC_PORT_STROBE : 0, "ior_n clocks");
            check(32'(iow_cnt - iow_base), s.r_w ? 0 : `SDMAC_PORT_STROBE, "iow_n clocks");
            check(32'(pd_oe), 32'h0, "pd_oe after the strobe");
            if (!s.r_w)
                check(32'(pd_cap), 32'(s.wdata[15:0]), "chip write data");
        end else begin
            check(32'(ior_cnt - ior_base + iow_cnt - iow_base), 32'h0, "stray port strobe");
        end
    endtask

    initial begin
        seed    = 32'h7bdbd1e4;
        reset   = 1'b1;
        cs_n    = 1'b1;
        as_n    = 1'b1;
        ds_n    = 1'b1;
        r_w     = 1'b1;
        addr    = '0;
        data_in = '0;
        inta    = 1'b0;
        intb    = 1'b0;
        build_table();
        repeat (4) @(posedge sclk);
        reset <= 1'b0;
        @(negedge sclk);
        check(32'({dsack_n, data_oe, pd_oe, css_n, csx0_n, csx1_n, ior_n, iow_n}), 32'h19f,
              "outputs after reset");
        foreach (steps[i])
            run_step(steps[i]);
        // Strobes with cs_n high must stay invisible
        @(posedge sclk);
        r_w  <= 1'b1;
        addr <= 5'b10000;
        as_n <= 1'b0;
        ds_n <= 1'b0;
        for (int i = 0; i < ack_limit; i++) begin
            @(negedge sclk);
            check(32'({dsack_n, ior_n, iow_n, css_n, csx0_n, csx1_n}), 32'h7f, "deselected cycle");
        end
        @(posedge sclk);
        as_n <= 1'b1;
        ds_n <= 1'b1;
        repeat (2) @(posedge sclk);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: sdmac_top.sv
// SDMAC slave top level; connects decode, registers, SCSI port and bus response
`timescale 1ns/1ps

module sdmac_top (
    input  logic        sclk,
    input  logic        reset,
    // CPU bus
    input  logic        cs_n,
    input  logic        as_n,
    input  logic        ds_n,
    input  logic        r_w,        // High for read
    input  logic [6:2]  addr,
    input  logic [31:0] data_in,
    output logic [31:0] data_out,
    output logic        data_oe,
    output logic [1:0]  dsack_n,
    // SCSI chip port
    output logic        css_n,
    output logic        csx0_n,
    output logic        csx1_n,
    output logic        ior_n,
    output logic        iow_n,
    input  logic [15:0] pd_in,
    output logic [15:0] pd_out,
    output logic        pd_oe,
    // Interrupt sources
    input  logic        inta,       // From the SCSI chip
    input  logic        intb        // Spare
);
    import sdmac_pkg::*;

    access_t acc;                   // Decoded access to both execute blocks
    resp_t   reg_resp;
    resp_t   port_resp;

    sdmac_addr_decode u_decode (
        .sclk       (sclk),
        .reset      (reset),
        .cs_n       (cs_n),
        .as_n       (as_n),
        .ds_n       (ds_n),
        .r_w        (r_w),
        .addr       (addr),
        .data_in    (data_in),
        .access     (acc),
        .cycle_open ()              // Internal use only
    );

    sdmac_registers u_regs (
        .sclk   (sclk),
        .reset  (reset),
        .access (acc),
        .inta   (inta),
        .intb   (intb),
        .resp   (reg_resp)
    );

    sdmac_io_port u_port (
        .sclk   (sclk),
        .reset  (reset),
        .access (acc),
        .pd_in  (pd_in),
        .resp   (port_resp),
        .css_n  (css_n),
        .csx0_n (csx0_n),
        .csx1_n (csx1_n),
        .ior_n  (ior_n),
        .iow_n  (iow_n),
        .pd_out (pd_out),
        .pd_oe  (pd_oe)
    );

    sdmac_bus_response u_resp (
        .sclk      (sclk),
        .reset     (reset),
        .as_n      (as_n),
        .r_w       (r_w),
        .reg_resp  (reg_resp),
        .port_resp (port_resp),
        .data_out  (data_out),
        .data_oe   (data_oe),
        .dsack_n   (dsack_n)
    );

endmodule

// File: sdmac_bus_response.sv
// Bus return path; merges register and port responses into data_out, data_oe and dsack_n
`timescale 1ns/1ps

module sdmac_bus_response (
    input  logic             sclk,
    input  logic             reset,
    input  logic             as_n,
    input  logic             r_w,
    input  sdmac_pkg::resp_t reg_resp,
    input  sdmac_pkg::resp_t port_resp,
    output logic [31:0]      data_out,
    output logic             data_oe,
    output logic [1:0]       dsack_n
);
    import sdmac_pkg::*;

    resp_t       merged;        // Whichever source is acking
    logic        any_ack;
    logic        as_q;          // Registered address strobe
    logic        held;          // Acknowledge currently on the bus
    logic [1:0]  dsack_q;
    logic        oe_q;
    logic [31:0] data_q;

    assign any_ack = reg_resp.ack | port_resp.ack;
    assign merged  = port_resp.ack ? port_resp : reg_resp;
    assign held    = (dsack_q != 2'b11);

    always_ff @(posedge sclk) begin
        if (reset) begin
            as_q    <= 1'b1;
            dsack_q <= 2'b11;           // Both acks negated
            oe_q    <= 1'b0;
        end else begin
            as_q <= as_n;
            if (any_ack) begin
                dsack_q <= merged.port16 ? 2'b01 : 2'b00;  // DSACK1 only for 16 bit
                oe_q    <= r_w;         // Drive data on reads only
            end else if (held && as_q) begin
                dsack_q <= 2'b11;       // Release a clock after as_n seen high
                oe_q    <= 1'b0;
            end
        end
    end

    always_ff @(posedge sclk) begin
        if (any_ack)
            data_q <= merged.rdata;
    end

    assign data_out = data_q;
    assign data_oe  = oe_q;
    assign dsack_n  = dsack_q;

    // Decode issues one access at a time so sources never collide
    ap_single_source: assert property (@(posedge sclk) disable iff (reset)
        !(reg_resp.ack && port_resp.ack));

    // No second ack before the current bus cycle has ended
    ap_ack_when_free: assert property (@(posedge sclk) disable iff (reset)
        any_ack |-> !held);

endmodule

// File: sdmac_io_port.sv
// Peripheral port for the SCSI chip; times chip select, ior_n/iow_n and data for 16-bit accesses
`timescale 1ns/1ps
`include "sdmac_defs.svh"

module sdmac_io_port (
    input  logic               sclk,
    input  logic               reset,
    input  sdmac_pkg::access_t access,
    input  logic [15:0]        pd_in,
    output sdmac_pkg::resp_t   resp,
    output logic               css_n,
    output logic               csx0_n,
    output logic               csx1_n,
    output logic               ior_n,
    output logic               iow_n,
    output logic [15:0]        pd_out,
    output logic               pd_oe
);
    import sdmac_pkg::*;

    localparam int SETUP  = `SDMAC_PORT_SETUP;
    localparam int STROBE = `SDMAC_PORT_STROBE;

    port_state_e state;
    logic [3:0]  cnt;           // Cycles spent in SETUP or STROBE
    logic        start;
    logic        last_strobe;   // Final strobe clock and read sample point
    logic [1:0]  sel_q;         // addr[3:2] of the access
    logic        rd_q;
    logic [15:0] wdata_q;
    logic [15:0] rdata_q;
    logic        ack_q;
    logic [2:0]  cs_vec;        // {csx1, csx0, css} active high

    assign start = access.valid && (state == PS_IDLE) &&
                   (access.op == OP_PORT_RD || access.op == OP_PORT_WR);
    assign last_strobe = (state == PS_STROBE) && (cnt == 4'(STROBE - 1));

    always_ff @(posedge sclk) begin
        if (reset) begin
            state <= PS_IDLE;
            cnt   <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= (state == PS_HOLD);   // Ack leaves on the HOLD clock
            case (state)
                PS_IDLE: begin
                    cnt <= '0;
                    if (start)
                        state <= PS_SETUP;
                end
                PS_SETUP: begin
                    if (cnt == 4'(SETUP - 1)) begin
                        state <= PS_STROBE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 4'd1;
                    end
                end
                PS_STROBE: begin
                    if (last_strobe) begin
                        state <= PS_HOLD;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 4'd1;
                    end
                end
                default: state <= PS_IDLE; // HOLD lasts one clock
            endcase
        end
    end

    always_ff @(posedge sclk) begin
        if (start) begin
            sel_q   <= access.reg_sel[1:0];
            rd_q    <= (access.op == OP_PORT_RD);
            wdata_q <= access.wdata[15:0];
        end
        if (last_strobe && rd_q)
            rdata_q <= pd_in;              // Chip data is stable by now
    end

    // Select held from SETUP through HOLD
    assign cs_vec[0] = (state != PS_IDLE) && (sel_q == 2'd0);
    assign cs_vec[1] = (state != PS_IDLE) && (sel_q == 2'd1 || sel_q == 2'd2);
    assign cs_vec[2] = (state != PS_IDLE) && (sel_q == 2'd3);

    assign css_n  = ~cs_vec[0];
    assign csx0_n = ~cs_vec[1];            // Port 1A and 1B share it
    assign csx1_n = ~cs_vec[2];

    assign ior_n  = ~((state == PS_STROBE) && rd_q);
    assign iow_n  = ~((state == PS_STROBE) && !rd_q);

    assign pd_oe  = !rd_q && (state == PS_SETUP || state == PS_STROBE);
    assign pd_out = wdata_q;               // Low half of the CPU word

    assign resp = '{ack: ack_q, rdata: {rdata_q, rdata_q}, port16: 1'b1};

    ap_no_dual_strobe: assert property (@(posedge sclk) disable iff (reset)
        !(!ior_n && !iow_n));

    // Strobe must land on exactly one selected chip
    ap_strobe_one_cs: assert property (@(posedge sclk) disable iff (reset)
        (!ior_n || !iow_n) |-> $onehot({~csx1_n, ~csx0_n, ~css_n}));

endmodule

// File: sdmac_registers.sv
// Internal SDMAC register file; answers register reads and writes one clock after the access
`timescale 1ns/1ps
`include "sdmac_defs.svh"

module sdmac_registers (
    input  logic               sclk,
    input  logic               reset,
    input  sdmac_pkg::access_t access,
    input  logic               inta,
    input  logic               intb,
    output sdmac_pkg::resp_t   resp
);
    import sdmac_pkg::*;

    logic [31:0]                  dawr;      // Full width read/write
    logic [`SDMAC_WTC_BITS-1:0]   wtc;       // Transfer count
    logic [`SDMAC_CNTR_BITS-1:0]  cntr;      // Control bits
    logic [1:0]                   int_q;     // {intb, inta} captured each clock
    logic                         reg_hit;   // Access aimed at this block
    logic                         wr_en;
    logic [31:0]                  rd_mux;
    logic [31:0]                  rdata_q;
    logic                         ack_q;

    assign reg_hit = access.valid &&
                     (access.op == OP_REG_RD || access.op == OP_REG_WR);
    assign wr_en   = access.valid && (access.op == OP_REG_WR);

    always_ff @(posedge sclk) begin
        if (reset) begin
            dawr  <= '0;
            wtc   <= '0;
            cntr  <= `SDMAC_CNTR_RESET;
            int_q <= '0;
            ack_q <= 1'b0;
        end else begin
            int_q <= {intb, inta};      // Free running capture
            ack_q <= reg_hit;           // Fixed one clock latency
            if (wr_en) begin
                case (access.reg_sel)
                    `SDMAC_REG_DAWR: dawr <= access.wdata;
                    `SDMAC_REG_WTC:  wtc  <= access.wdata[`SDMAC_WTC_BITS-1:0];
                    `SDMAC_REG_CNTR: cntr <= access.wdata[`SDMAC_CNTR_BITS-1:0];
                    default: ;          // ISTR and unused slots drop the write
                endcase
            end
        end
    end

    // Read mux with zero extension of the narrow registers
    always_comb begin
        rd_mux = '0;                    // Unused offsets read zero
        case (access.reg_sel)
            `SDMAC_REG_DAWR: rd_mux = dawr;
            `SDMAC_REG_WTC:  rd_mux = 32'(wtc);
            `SDMAC_REG_CNTR: rd_mux = 32'(cntr);
            `SDMAC_REG_ISTR: rd_mux = {30'd0, int_q};
            default: ;
        endcase
    end

    always_ff @(posedge sclk) begin
        if (reg_hit)
            rdata_q <= rd_mux;          // Value before any same-clock write
    end

    assign resp = '{ack: ack_q, rdata: rdata_q, port16: 1'b0};

    // Every register access gets exactly one ack on the next clock
    ap_ack_follows: assert property (@(posedge sclk) disable iff (reset)
        reg_hit |=> resp.ack);

endmodule

// File: sdmac_addr_decode.sv
// Bus front end; registers the 68030 strobes and issues one classified access per bus cycle
`timescale 1ns/1ps
`include "sdmac_defs.svh"

module sdmac_addr_decode (
    input  logic               sclk,
    input  logic               reset,
    input  logic               cs_n,
    input  logic               as_n,
    input  logic               ds_n,
    input  logic               r_w,
    input  logic [6:2]         addr,
    input  logic [31:0]        data_in,
    output sdmac_pkg::access_t access,
    output logic               cycle_open
);
    import sdmac_pkg::*;

    logic        cs_q, as_q, ds_q;     // Registered strobes (active low)
    logic        r_w_q;
    logic [6:2]  addr_q;
    logic [31:0] data_q;
    logic        start;                // First clock of a new bus cycle
    logic        valid_q;
    access_op_e  op_d, op_q;
    logic [3:0]  sel_q;
    logic [31:0] wdata_q;

    always_ff @(posedge sclk) begin
        if (reset) begin
            cs_q <= 1'b1;               // Idle bus
            as_q <= 1'b1;
            ds_q <= 1'b1;
        end else begin
            cs_q <= cs_n;
            as_q <= as_n;
            ds_q <= ds_n;
        end
    end

    // Sampled on the same edge as the strobes so they line up
    always_ff @(posedge sclk) begin
        r_w_q  <= r_w;
        addr_q <= addr;
        data_q <= data_in;
    end

    always_comb begin
        if (addr_q[6])
            op_d = r_w_q ? OP_PORT_RD : OP_PORT_WR;   // Upper half is the port
        else if (addr_q[5:2] == `SDMAC_REG_HOLE)
            op_d = OP_NONE;                           // Hole stays silent
        else
            op_d = r_w_q ? OP_REG_RD : OP_REG_WR;
    end

    assign start = !cs_q && !as_q && !ds_q && !cycle_open;

    always_ff @(posedge sclk) begin
        if (reset) begin
            valid_q    <= 1'b0;
            cycle_open <= 1'b0;
        end else begin
            valid_q <= start;           // Single clock pulse
            if (start)
                cycle_open <= 1'b1;
            else if (as_q)
                cycle_open <= 1'b0;     // Closes when as_n seen high
        end
    end

    always_ff @(posedge sclk) begin
        if (start) begin
            op_q    <= op_d;
            sel_q   <= addr_q[5:2];
            wdata_q <= data_q;
        end
    end

    assign access = '{valid: valid_q, op: op_q, reg_sel: sel_q, wdata: wdata_q};

    // Only one access may leave per bus cycle
    ap_one_per_cycle: assert property (@(posedge sclk) disable iff (reset)
        access.valid |-> !$past(cycle_open));

endmodule

// File: sdmac_pkg.sv
// Shared types for the SDMAC slave; imported by the decode, register, port and response blocks
package sdmac_pkg;

    // Kind of access found by the address decode
    typedef enum logic [2:0] {
        OP_NONE    = 3'd0,  // Hole or nothing to do
        OP_REG_RD  = 3'd1,  // Internal register read
        OP_REG_WR  = 3'd2,  // Internal register write
        OP_PORT_RD = 3'd3,  // SCSI chip read through the port
        OP_PORT_WR = 3'd4   // SCSI chip write through the port
    } access_op_e;

    // Peripheral port sequencer
    typedef enum logic [1:0] {
        PS_IDLE   = 2'd0,   // No port access in flight
        PS_SETUP  = 2'd1,   // Select low with strobe still high
        PS_STROBE = 2'd2,   // ior_n or iow_n low
        PS_HOLD   = 2'd3    // Strobe released with select held
    } port_state_e;

    // One decoded bus access (40 bits)
    typedef struct packed {
        logic        valid;    // One clock per bus cycle
        access_op_e  op;
        logic [3:0]  reg_sel;  // addr[5:2]
        logic [31:0] wdata;
    } access_t;

    // One response back to the bus side (34 bits)
    typedef struct packed {
        logic        ack;      // One clock pulse
        logic [31:0] rdata;
        logic        port16;   // Acknowledge as a 16-bit port
    } resp_t;

endpackage

// File: sdmac_defs.svh
// Port timing, register map and reset constants for the SDMAC slave; include wherever they are used
`ifndef SDMAC_DEFS_SVH
`define SDMAC_DEFS_SVH

// Peripheral port timing in sclk cycles
`define SDMAC_PORT_SETUP   1       // Select low before strobe (at least 1)
`define SDMAC_PORT_STROBE  3       // Width of ior_n or iow_n low (at least 1)

// Register offsets as seen on addr[5:2]
`define SDMAC_REG_DAWR     4'd0    // DACK width register
`define SDMAC_REG_WTC      4'd1    // Word transfer count
`define SDMAC_REG_CNTR     4'd2    // Control register
`define SDMAC_REG_HOLE     4'd3    // Unmapped slot that never acknowledges
`define SDMAC_REG_ISTR     4'd4    // Interrupt status (read only)

// Implemented register widths
`define SDMAC_WTC_BITS     24      // Upper byte reads as zero
`define SDMAC_CNTR_BITS    9

// Reset value of the control register
`define SDMAC_CNTR_RESET   9'h004  // Interrupt enable set out of reset

`endif
